// ==== if_consts.svh ====
`ifndef IF_CONSTS_SVH
`define IF_CONSTS_SVH

`default_nettype none

////////////////////
// fetch buffer sizing
////////////////////

// word entries in the fetch fifo
`define IF_FIFO_DEPTH 4

// request credit, depth minus current occupancy
`define IF_MAX_OUTSTANDING(occ) (`IF_FIFO_DEPTH - (occ))

// low byte of the reset entry, placed over boot_addr[31:8]
`define IF_RST_OFFSET 8'h80

////////////////////
// opcodes emitted by the expander
////////////////////

`define OPC_OP_IMM 7'b0010011
`define OPC_LUI    7'b0110111
`define OPC_OP     7'b0110011
`define OPC_JAL    7'b1101111
`define OPC_LOAD   7'b0000011
`define OPC_STORE  7'b0100011
`define OPC_BRANCH 7'b1100011

`default_nettype wire

`endif

// ==== if_pkg.sv ====
`default_nettype none

package if_pkg;

  // one fetched word, seen whole or as two halfwords
  // lo holds bits 15:0, hi holds bits 31:16
  typedef union packed {
    logic [31:0] word;
    struct packed {
      logic [15:0] hi;
      logic [15:0] lo;
    } half;
  } instr_word_u;

  // offset FSM of the aligner
  // idle only right after reset, before the boot branch
  typedef enum logic [1:0] {
    IDLE,
    WAIT_ALIGNED,
    WAIT_UNALIGNED
  } align_state_e;

endpackage

`default_nettype wire

// ==== fetch_requester.sv ====
`timescale 1ns/1ps
`include "if_consts.svh"
`default_nettype none

module fetch_requester (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        branch_i,
  input  logic [31:0] branch_addr_i,
  input  logic [2:0]  fifo_free_i,
  input  logic        instr_gnt_i,
  input  logic        instr_rvalid_i,
  input  logic [31:0] instr_rdata_i,
  output logic        instr_req_o,
  output logic [31:0] instr_addr_o,
  output logic        resp_valid_o,
  output logic [31:0] resp_rdata_o,
  output logic [31:0] resp_addr_o
);

  logic [31:0] fetch_addr_q;
  logic [31:0] resp_addr_q;
  logic [31:0] req_addr_q;
  logic [31:0] target;
  logic [2:0]  out_q;
  logic [2:0]  stale_q;
  logic [2:0]  in_flight;
  logic [2:0]  credit;
  logic        req_pend_q;
  logic        drop_req_q;
  logic        old_req;
  logic        req_ok;
  logic        gnt_acc;
  logic        live_gnt;
  logic        stale_gnt;
  logic        stale_drop;

  assign target = {branch_addr_i[31:2], 2'b00};

  // responses arriving now leave the in-flight count and enter the fifo together
  assign in_flight = out_q - {2'b00, instr_rvalid_i};
  assign credit    = fifo_free_i - {2'b00, resp_valid_o};
  // on a redirect the fifo is flushed, so the full depth is free
  // no request goes out while reset is held
  assign req_ok    = rst_n &
                     (branch_i ? (in_flight < 3'(`IF_FIFO_DEPTH)) : (in_flight < credit));

  // a request left ungranted across a redirect still has to complete
  assign old_req = req_pend_q & (drop_req_q | branch_i);

  always_comb begin
    if (old_req) begin
      instr_req_o  = 1'b1;
      instr_addr_o = req_addr_q;
    end else if (branch_i) begin
      instr_req_o  = req_ok;
      instr_addr_o = target;
    end else begin
      instr_req_o  = req_ok;
      instr_addr_o = fetch_addr_q;
    end
  end

  assign gnt_acc    = instr_req_o & instr_gnt_i;
  assign live_gnt   = gnt_acc & ~old_req;
  assign stale_gnt  = gnt_acc & old_req;
  assign stale_drop = instr_rvalid_i & (stale_q != 3'd0);

  // stale responses are swallowed here and never reach the fifo
  assign resp_valid_o = instr_rvalid_i & (stale_q == 3'd0) & ~branch_i;
  assign resp_rdata_o = instr_rdata_i;
  assign resp_addr_o  = resp_addr_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fetch_addr_q <= '0;
      resp_addr_q  <= '0;
      out_q        <= '0;
      stale_q      <= '0;
      req_pend_q   <= 1'b0;
      drop_req_q   <= 1'b0;
    end else begin
      out_q      <= out_q + {2'b00, gnt_acc} - {2'b00, instr_rvalid_i};
      req_pend_q <= instr_req_o & ~instr_gnt_i;
      drop_req_q <= old_req & ~instr_gnt_i;
      if (branch_i) begin
        // everything still owed now belongs to the old stream
        stale_q      <= out_q - {2'b00, instr_rvalid_i} + {2'b00, stale_gnt};
        fetch_addr_q <= live_gnt ? target + 32'd4 : target;
        resp_addr_q  <= target;
      end else begin
        stale_q <= stale_q + {2'b00, stale_gnt} - {2'b00, stale_drop};
        if (live_gnt) begin
          fetch_addr_q <= fetch_addr_q + 32'd4;
        end
        if (resp_valid_o) begin
          resp_addr_q <= resp_addr_q + 32'd4;
        end
      end
    end
  end

  // bus address kept for replay while the request waits for a grant
  always_ff @(posedge clk) begin
    req_addr_q <= instr_addr_o;
  end

endmodule

`default_nettype wire

// ==== fetch_fifo.sv ====
`timescale 1ns/1ps
`include "if_consts.svh"
`default_nettype none

module fetch_fifo (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                flush_i,
  input  logic                wr_valid_i,
  input  logic [31:0]         wr_rdata_i,
  input  logic [31:0]         wr_addr_i,
  input  logic                rd_ready_i,
  output logic [2:0]          free_o,
  output logic                rd_valid_o,
  output if_pkg::instr_word_u rd_rdata_o,
  output logic [31:0]         rd_addr_o,
  output logic                rd_next_valid_o,
  output logic [15:0]         rd_next_lo_o
);

  import if_pkg::*;

  localparam int AW = $clog2(`IF_FIFO_DEPTH);

  instr_word_u   data_q [`IF_FIFO_DEPTH];
  logic [31:0]   addr_q [`IF_FIFO_DEPTH];
  logic [AW-1:0] wr_ptr_q;
  logic [AW-1:0] rd_ptr_q;
  logic [AW-1:0] nxt_ptr;
  logic [AW:0]   count_q;
  logic          push;
  logic          pop;

  // flush wins over both sides in the same edge
  assign push = wr_valid_i & ~flush_i;
  assign pop  = rd_valid_o & rd_ready_i & ~flush_i;

  ////////////////////
  // read side
  ////////////////////

  // entry after the head, wraps with the pointer width
  assign nxt_ptr = rd_ptr_q + 1'b1;

  assign rd_valid_o      = (count_q != '0);
  assign rd_next_valid_o = (count_q > (AW+1)'(1));
  assign rd_rdata_o      = data_q[rd_ptr_q];
  assign rd_addr_o       = addr_q[rd_ptr_q];
  // low half of the following word, for splicing an unaligned instruction
  assign rd_next_lo_o    = data_q[nxt_ptr].half.lo;

  assign free_o = 3'(`IF_MAX_OUTSTANDING(count_q));

  ////////////////////
  // pointers and occupancy
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= nxt_ptr;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // storage, word and its fetch address side by side
  always_ff @(posedge clk) begin
    if (push) begin
      data_q[wr_ptr_q].word <= wr_rdata_i;
      addr_q[wr_ptr_q]      <= wr_addr_i;
    end
  end

endmodule

`default_nettype wire

// ==== compressed_expander.sv ====
`timescale 1ns/1ps
`include "if_consts.svh"
`default_nettype none

module compressed_expander (
  input  if_pkg::instr_word_u instr_i,
  output logic [31:0]         instr_o,
  output logic                compressed_o,
  output logic                illegal_o
);

  logic [15:0] c;
  logic [2:0]  funct3;

  assign c            = instr_i.half.lo;
  assign funct3       = c[15:13];
  // anything other than 2'b11 in the low bits is a 16-bit encoding
  assign compressed_o = (c[1:0] != 2'b11);

  always_comb begin
    instr_o   = instr_i.word;
    illegal_o = 1'b0;
    if (compressed_o) begin
      // unsupported encodings fall through as illegal with zero data
      instr_o   = '0;
      illegal_o = 1'b1;
      case ({c[1:0], funct3})
        // c.lw -> lw rd', imm(rs1')
        5'b00_010: begin
          instr_o   = {5'b0, c[5], c[12:10], c[6], 2'b00, 2'b01, c[9:7], 3'b010,
                       2'b01, c[4:2], `OPC_LOAD};
          illegal_o = 1'b0;
        end
        // c.sw -> sw rs2', imm(rs1')
        5'b00_110: begin
          instr_o   = {5'b0, c[5], c[12], 2'b01, c[4:2], 2'b01, c[9:7], 3'b010,
                       c[11:10], c[6], 2'b00, `OPC_STORE};
          illegal_o = 1'b0;
        end
        // c.addi -> addi rd, rd, imm
        5'b01_000: begin
          instr_o   = {{7{c[12]}}, c[6:2], c[11:7], 3'b000, c[11:7], `OPC_OP_IMM};
          illegal_o = 1'b0;
        end
        // c.li -> addi rd, x0, imm
        5'b01_010: begin
          instr_o   = {{7{c[12]}}, c[6:2], 5'b0, 3'b000, c[11:7], `OPC_OP_IMM};
          illegal_o = 1'b0;
        end
        // c.lui, rd x2 would be c.addi16sp and a zero imm is reserved
        5'b01_011: begin
          if (c[11:7] != 5'd2 && {c[12], c[6:2]} != 6'd0) begin
            instr_o   = {{15{c[12]}}, c[6:2], c[11:7], `OPC_LUI};
            illegal_o = 1'b0;
          end
        end
        // c.j -> jal x0, offset
        5'b01_101: begin
          instr_o   = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                       c[12], {8{c[12]}}, 5'b0, `OPC_JAL};
          illegal_o = 1'b0;
        end
        // c.beqz -> beq rs1', x0, offset
        5'b01_110: begin
          instr_o   = {c[12], {3{c[12]}}, c[6:5], c[2], 5'b0, 2'b01, c[9:7], 3'b000,
                       c[11:10], c[4:3], c[12], `OPC_BRANCH};
          illegal_o = 1'b0;
        end
        // c.mv and c.add, rs2 of zero is jr, jalr or ebreak
        5'b10_100: begin
          if (c[6:2] != 5'd0) begin
            instr_o   = {7'b0, c[6:2], c[12] ? c[11:7] : 5'b0, 3'b000, c[11:7], `OPC_OP};
            illegal_o = 1'b0;
          end
        end
        default: begin
          instr_o   = '0;
          illegal_o = 1'b1;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== instr_aligner.sv ====
`timescale 1ns/1ps
`include "if_consts.svh"
`default_nettype none

module instr_aligner (
  input  logic                clk,
  input  logic                rst_n,
  input  logic [31:0]         boot_addr_i,
  input  logic                pc_set_i,
  input  logic [31:0]         pc_target_i,
  input  logic                fetch_valid_i,
  input  if_pkg::instr_word_u fetch_rdata_i,
  input  logic [31:0]         fetch_addr_i,
  input  logic                fetch_next_valid_i,
  input  logic [15:0]         fetch_next_lo_i,
  input  logic                instr_ready_i,
  output logic                fetch_ready_o,
  output logic                fetch_branch_o,
  output logic [31:0]         fetch_branch_addr_o,
  output logic                instr_valid_o,
  output logic [31:0]         instr_rdata_o,
  output logic [31:0]         instr_pc_o,
  output logic                instr_compressed_o,
  output logic                instr_illegal_o
);

  import if_pkg::*;

  align_state_e state_q;
  align_state_e state_n;
  instr_word_u  cand;
  logic [31:0]  exp_addr_q;
  logic [31:0]  exp_addr_n;
  logic [31:0]  branch_addr;
  logic [31:0]  cand_pc;
  logic [31:0]  exp_rdata;
  logic         exp_c;
  logic         exp_ill;
  logic         unaligned;
  logic         head_match;
  logic         is_c_lo;
  logic         is_c_hi;
  logic         avail;
  logic         last_half;
  logic         skip;
  logic         take;
  logic         can_load;

  ////////////////////
  // redirect
  ////////////////////

  // pc_set beats the one-time boot branch out of idle
  assign branch_addr         = pc_set_i ? pc_target_i : {boot_addr_i[31:8], `IF_RST_OFFSET};
  assign fetch_branch_o      = pc_set_i | (state_q == IDLE);
  assign fetch_branch_addr_o = {branch_addr[31:2], 2'b00};

  ////////////////////
  // offset FSM
  ////////////////////

  assign unaligned  = (state_q == WAIT_UNALIGNED);
  // words from before a jump do not match and get skipped
  assign head_match = (fetch_addr_i[31:2] == exp_addr_q[31:2]);
  assign is_c_lo    = (fetch_rdata_i.half.lo[1:0] != 2'b11);
  assign is_c_hi    = (fetch_rdata_i.half.hi[1:0] != 2'b11);
  assign can_load   = ~instr_valid_o | instr_ready_i;
  assign cand_pc    = {fetch_addr_i[31:2], unaligned, 1'b0};

  always_comb begin
    cand.word = fetch_rdata_i.word;
    avail     = 1'b0;
    last_half = 1'b0;
    case (state_q)
      WAIT_ALIGNED: begin
        avail     = fetch_valid_i & head_match;
        // a compressed low half leaves the high half in the fifo
        last_half = ~is_c_lo;
      end
      WAIT_UNALIGNED: begin
        // high half first, spliced with the next word's low half
        cand.half.lo = fetch_rdata_i.half.hi;
        cand.half.hi = fetch_next_lo_i;
        avail        = fetch_valid_i & head_match & (is_c_hi | fetch_next_valid_i);
        last_half    = 1'b1;
      end
      default: begin
        avail     = 1'b0;
        last_half = 1'b0;
      end
    endcase

    skip = fetch_valid_i & ~head_match & (state_q != IDLE);
    take = avail & can_load & ~pc_set_i;

    // pop exactly when the head's last halfword is gone
    fetch_ready_o = ~fetch_branch_o & (skip | (take & last_half));

    state_n    = state_q;
    exp_addr_n = exp_addr_q;
    if (take) begin
      if (unaligned) begin
        state_n = is_c_hi ? WAIT_ALIGNED : WAIT_UNALIGNED;
      end else begin
        state_n = is_c_lo ? WAIT_UNALIGNED : WAIT_ALIGNED;
      end
      if (last_half) begin
        exp_addr_n = exp_addr_q + 32'd4;
      end
    end
    if (fetch_branch_o) begin
      state_n    = branch_addr[1] ? WAIT_UNALIGNED : WAIT_ALIGNED;
      exp_addr_n = fetch_branch_addr_o;
    end
  end

  compressed_expander u_expander (
    .instr_i      (cand),
    .instr_o      (exp_rdata),
    .compressed_o (exp_c),
    .illegal_o    (exp_ill)
  );

  ////////////////////
  // IF/ID register
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q       <= IDLE;
      exp_addr_q    <= '0;
      instr_valid_o <= 1'b0;
    end else begin
      state_q    <= state_n;
      exp_addr_q <= exp_addr_n;
      if (pc_set_i) begin
        instr_valid_o <= 1'b0;
      end else if (can_load) begin
        instr_valid_o <= take;
      end
    end
  end

  // held while decode stalls, take is low then
  always_ff @(posedge clk) begin
    if (take) begin
      instr_rdata_o      <= exp_rdata;
      instr_pc_o         <= cand_pc;
      instr_compressed_o <= exp_c;
      instr_illegal_o    <= exp_ill;
    end
  end

endmodule

`default_nettype wire

// ==== if_stage_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module if_stage_top (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [31:0] boot_addr_i,
  input  logic        pc_set_i,
  input  logic [31:0] pc_target_i,
  input  logic        instr_ready_i,
  input  logic        instr_gnt_i,
  input  logic        instr_rvalid_i,
  input  logic [31:0] instr_rdata_i,
  output logic        instr_req_o,
  output logic [31:0] instr_addr_o,
  output logic        instr_valid_o,
  output logic [31:0] instr_rdata_o,
  output logic [31:0] instr_pc_o,
  output logic        instr_compressed_o,
  output logic        instr_illegal_o
);

  import if_pkg::*;

  // redirect from aligner to requester and fifo
  logic        fetch_branch;
  logic [31:0] fetch_branch_addr;

  // requester to fifo
  logic [2:0]  fifo_free;
  logic        resp_valid;
  logic [31:0] resp_rdata;
  logic [31:0] resp_addr;

  // fifo to aligner
  logic        fetch_valid;
  logic        fetch_ready;
  instr_word_u fetch_rdata;
  logic [31:0] fetch_addr;
  logic        fetch_next_valid;
  logic [15:0] fetch_next_lo;

  fetch_requester u_requester (
    .clk            (clk),
    .rst_n          (rst_n),
    .branch_i       (fetch_branch),
    .branch_addr_i  (fetch_branch_addr),
    .fifo_free_i    (fifo_free),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .resp_valid_o   (resp_valid),
    .resp_rdata_o   (resp_rdata),
    .resp_addr_o    (resp_addr)
  );

  fetch_fifo u_fifo (
    .clk             (clk),
    .rst_n           (rst_n),
    .flush_i         (fetch_branch),
    .wr_valid_i      (resp_valid),
    .wr_rdata_i      (resp_rdata),
    .wr_addr_i       (resp_addr),
    .rd_ready_i      (fetch_ready),
    .free_o          (fifo_free),
    .rd_valid_o      (fetch_valid),
    .rd_rdata_o      (fetch_rdata),
    .rd_addr_o       (fetch_addr),
    .rd_next_valid_o (fetch_next_valid),
    .rd_next_lo_o    (fetch_next_lo)
  );

  instr_aligner u_aligner (
    .clk                 (clk),
    .rst_n               (rst_n),
    .boot_addr_i         (boot_addr_i),
    .pc_set_i            (pc_set_i),
    .pc_target_i         (pc_target_i),
    .fetch_valid_i       (fetch_valid),
    .fetch_rdata_i       (fetch_rdata),
    .fetch_addr_i        (fetch_addr),
    .fetch_next_valid_i  (fetch_next_valid),
    .fetch_next_lo_i     (fetch_next_lo),
    .instr_ready_i       (instr_ready_i),
    .fetch_ready_o       (fetch_ready),
    .fetch_branch_o      (fetch_branch),
    .fetch_branch_addr_o (fetch_branch_addr),
    .instr_valid_o       (instr_valid_o),
    .instr_rdata_o       (instr_rdata_o),
    .instr_pc_o          (instr_pc_o),
    .instr_compressed_o  (instr_compressed_o),
    .instr_illegal_o     (instr_illegal_o)
  );

endmodule

`default_nettype wire

// ==== if_stage_asserts.sv ====
`timescale 1ns/1ps
`include "if_consts.svh"
`default_nettype none

module if_stage_asserts (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        instr_req_o,
  input  logic [31:0] instr_addr_o,
  input  logic        instr_gnt_i,
  input  logic        pc_set_i,
  input  logic        instr_valid_o,
  input  logic        instr_ready_i,
  input  logic [31:0] instr_rdata_o,
  input  logic [31:0] instr_pc_o,
  input  logic        instr_compressed_o,
  input  logic        instr_illegal_o,
  input  logic [2:0]  fifo_free_i
);

  ////////////////////
  // memory port
  ////////////////////

  // an ungranted request stays up with the same address
  req_held_a: assert property (@(posedge clk) disable iff (!rst_n)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o))
    else $error("fetch request dropped or address changed before its grant");

  ////////////////////
  // decode port
  ////////////////////

  // a stalled instruction keeps every field until decode takes it
  out_held_a: assert property (@(posedge clk) disable iff (!rst_n)
    instr_valid_o && !instr_ready_i && !pc_set_i |=>
      instr_valid_o && $stable(instr_rdata_o) && $stable(instr_pc_o) &&
      $stable(instr_compressed_o) && $stable(instr_illegal_o))
    else $error("IF/ID output changed while decode was stalling");

  ////////////////////
  // fetch fifo
  ////////////////////

  // occupancy is depth minus free, so an overflow wraps free past the depth
  fifo_bound_a: assert property (@(posedge clk) disable iff (!rst_n)
    fifo_free_i <= 3'(`IF_FIFO_DEPTH))
    else $error("fetch fifo holds more words than its depth");

endmodule

bind if_stage_top if_stage_asserts u_asserts (
  .clk                (clk),
  .rst_n              (rst_n),
  .instr_req_o        (instr_req_o),
  .instr_addr_o       (instr_addr_o),
  .instr_gnt_i        (instr_gnt_i),
  .pc_set_i           (pc_set_i),
  .instr_valid_o      (instr_valid_o),
  .instr_ready_i      (instr_ready_i),
  .instr_rdata_o      (instr_rdata_o),
  .instr_pc_o         (instr_pc_o),
  .instr_compressed_o (instr_compressed_o),
  .instr_illegal_o    (instr_illegal_o),
  .fifo_free_i        (fifo_free)
);

`default_nettype wire

// ==== if_stage_tb.sv ====
`timescale 1ns/1ps
`include "if_consts.svh"
`default_nettype none

module if_stage_tb;

  localparam int          MEM_HW    = 512;
  localparam int          TOTAL     = 600;
  localparam int          TIMEOUT   = 20 * TOTAL;
  localparam int          ALIGNED_N = 32;
  localparam int          MIXED_N   = 150;
  localparam int          BP_N      = 300;
  localparam logic [31:0] SEED      = 32'h276f4884;
  localparam logic [31:0] BOOT_ADDR = 32'h1c00_0012;
  localparam logic [31:0] ENTRY     = {BOOT_ADDR[31:8], `IF_RST_OFFSET};
  localparam logic [31:0] MEM_BASE  = {BOOT_ADDR[31:10], 10'b0};
  localparam int          ENTRY_HW  = int'(ENTRY[9:1]);

  logic        clk = 1'b0;
  logic        rst_n;
  logic [31:0] boot_addr_i;
  logic        pc_set_i;
  logic [31:0] pc_target_i;
  logic        instr_ready_i;
  logic        instr_gnt_i;
  logic        instr_rvalid_i;
  logic [31:0] instr_rdata_i;
  logic        instr_req_o;
  logic [31:0] instr_addr_o;
  logic        instr_valid_o;
  logic [31:0] instr_rdata_o;
  logic [31:0] instr_pc_o;
  logic        instr_compressed_o;
  logic        instr_illegal_o;

  // program image with the expected decode at each instruction start
  logic [15:0] mem_hw   [MEM_HW];
  logic [31:0] exp_word [MEM_HW];
  logic        exp_c    [MEM_HW];
  logic        exp_ill  [MEM_HW];
  int          exp_len  [MEM_HW];
  logic        is_start [MEM_HW];

  // in-order responses still owed by the memory model
  logic [31:0] rsp_data_q [$];
  int          rsp_due_q  [$];

  int          cyc;
  int          last_due;
  int          timeout_cnt;
  int          n_done;
  int          n_errors;
  int          n_checks;
  int          n_redirects;
  int          n_illegal;
  int          n_compressed;
  int          n_unaligned;
  logic [31:0] model_pc;
  logic        first_cycle;
  logic        after_set;

  if_stage_top u_dut (
    .clk                (clk),
    .rst_n              (rst_n),
    .boot_addr_i        (boot_addr_i),
    .pc_set_i           (pc_set_i),
    .pc_target_i        (pc_target_i),
    .instr_ready_i      (instr_ready_i),
    .instr_gnt_i        (instr_gnt_i),
    .instr_rvalid_i     (instr_rvalid_i),
    .instr_rdata_i      (instr_rdata_i),
    .instr_req_o        (instr_req_o),
    .instr_addr_o       (instr_addr_o),
    .instr_valid_o      (instr_valid_o),
    .instr_rdata_o      (instr_rdata_o),
    .instr_pc_o         (instr_pc_o),
    .instr_compressed_o (instr_compressed_o),
    .instr_illegal_o    (instr_illegal_o)
  );

  always #50 clk = ~clk;

  ////////////////////
  // memory image
  ////////////////////

  // 1 KiB image repeating every 1024 bytes of address space
  function automatic int hw_index(input logic [31:0] addr);
    return int'(addr[9:1]);
  endfunction

  function automatic logic [31:0] read_word(input logic [31:0] addr);
    int idx;
    idx = hw_index({addr[31:2], 2'b00});
    return {mem_hw[idx + 1], mem_hw[idx]};
  endfunction

  // random supported RVC instruction with its expected form built from the fields
  task automatic make_compressed(output logic [15:0] c, output logic [31:0] w);
    logic [4:0]  rd;
    logic [4:0]  rs2;
    logic [2:0]  rp;
    logic [2:0]  rq;
    logic [5:0]  imm;
    logic [6:0]  uimm;
    logic [11:0] joff;
    logic [8:0]  boff;
    logic [20:0] jimm;
    logic [12:0] bimm;
    logic [11:0] simm;
    int          sel;
    rd   = 5'($urandom);
    rs2  = 5'($urandom);
    rp   = 3'($urandom);
    rq   = 3'($urandom);
    imm  = 6'($urandom);
    uimm = {5'($urandom), 2'b00};
    joff = {11'($urandom), 1'b0};
    boff = {8'($urandom), 1'b0};
    jimm = {{9{joff[11]}}, joff};
    bimm = {{4{boff[8]}}, boff};
    simm = {5'b0, uimm};
    sel  = int'($urandom % 9);
    case (sel)
      // c.addi
      0: begin
        c = {3'b000, imm[5], rd, imm[4:0], 2'b01};
        w = {{6{imm[5]}}, imm, rd, 3'b000, rd, `OPC_OP_IMM};
      end
      // c.li
      1: begin
        c = {3'b010, imm[5], rd, imm[4:0], 2'b01};
        w = {{6{imm[5]}}, imm, 5'd0, 3'b000, rd, `OPC_OP_IMM};
      end
      // c.lui avoids x2 and a zero immediate, which are other encodings
      2: begin
        if (rd == 5'd2) rd = 5'd3;
        if (imm == 6'd0) imm = 6'd1;
        c = {3'b011, imm[5], rd, imm[4:0], 2'b01};
        w = {{14{imm[5]}}, imm, rd, `OPC_LUI};
      end
      // c.mv
      3: begin
        if (rs2 == 5'd0) rs2 = 5'd1;
        c = {4'b1000, rd, rs2, 2'b10};
        w = {7'b0, rs2, 5'd0, 3'b000, rd, `OPC_OP};
      end
      // c.add
      4: begin
        if (rs2 == 5'd0) rs2 = 5'd1;
        c = {4'b1001, rd, rs2, 2'b10};
        w = {7'b0, rs2, rd, 3'b000, rd, `OPC_OP};
      end
      // c.j
      5: begin
        c = {3'b101, joff[11], joff[4], joff[9:8], joff[10], joff[6], joff[7],
             joff[3:1], joff[5], 2'b01};
        w = {jimm[20], jimm[10:1], jimm[11], jimm[19:12], 5'd0, `OPC_JAL};
      end
      // c.lw
      6: begin
        c = {3'b010, uimm[5:3], rp, uimm[2], uimm[6], rq, 2'b00};
        w = {simm, 2'b01, rp, 3'b010, 2'b01, rq, `OPC_LOAD};
      end
      // c.sw
      7: begin
        c = {3'b110, uimm[5:3], rp, uimm[2], uimm[6], rq, 2'b00};
        w = {simm[11:5], 2'b01, rq, 2'b01, rp, 3'b010, simm[4:0], `OPC_STORE};
      end
      // c.beqz
      default: begin
        c = {3'b110, boff[8], boff[4:3], rp, boff[7:6], boff[2:1], boff[5], 2'b01};
        w = {bimm[12], bimm[10:5], 5'd0, 2'b01, rp, 3'b000, bimm[4:1], bimm[11],
             `OPC_BRANCH};
      end
    endcase
  endtask

  // addi4spn, slli, misc-alu and lwsp groups are outside the subset
  task automatic make_illegal(output logic [15:0] c);
    int grp;
    c   = 16'($urandom);
    grp = int'($urandom % 4);
    case (grp)
      0:       {c[15:13], c[1:0]} = 5'b000_00;
      1:       {c[15:13], c[1:0]} = 5'b000_10;
      2:       {c[15:13], c[1:0]} = 5'b100_01;
      default: {c[15:13], c[1:0]} = 5'b010_10;
    endcase
  endtask

  task automatic fill_program();
    int          idx;
    int          kind;
    logic [15:0] c;
    logic [31:0] w;
    for (idx = 0; idx < MEM_HW; idx++) begin
      is_start[idx] = 1'b0;
      exp_word[idx] = '0;
      exp_c[idx]    = 1'b0;
      exp_ill[idx]  = 1'b0;
      exp_len[idx]  = 2;
    end
    idx = 0;
    while (idx < MEM_HW) begin
      kind = int'($urandom % 20);
      kind = (kind < 8) ? 0 : ((kind < 17) ? 1 : 2);
      // boot region holds only full words
      if (idx >= ENTRY_HW && idx < ENTRY_HW + 2 * ALIGNED_N) kind = 0;
      // keep the boot entry and the wrap point on instruction starts
      if ((idx == ENTRY_HW - 1 || idx == MEM_HW - 1) && kind == 0) kind = 1;
      is_start[idx] = 1'b1;
      if (kind == 0) begin
        w      = $urandom;
        w[1:0] = 2'b11;
        mem_hw[idx]     = w[15:0];
        mem_hw[idx + 1] = w[31:16];
        exp_word[idx]   = w;
        exp_len[idx]    = 4;
        idx += 2;
      end else begin
        if (kind == 1) begin
          make_compressed(c, w);
        end else begin
          make_illegal(c);
          w            = '0;
          exp_ill[idx] = 1'b1;
        end
        mem_hw[idx]   = c;
        exp_word[idx] = w;
        exp_c[idx]    = 1'b1;
        idx += 1;
      end
    end
  endtask

  // redirects land on instruction starts only
  function automatic logic [31:0] pick_target();
    int idx;
    idx = int'($urandom % MEM_HW);
    while (!is_start[idx]) begin
      idx = (idx + 1) % MEM_HW;
    end
    return MEM_BASE + 32'(idx * 2);
  endfunction

  ////////////////////
  // checking
  ////////////////////

  function automatic string phase_name();
    if (n_done < ALIGNED_N) return "aligned";
    if (n_done < MIXED_N)   return "mixed";
    if (n_done < BP_N)      return "backpressure";
    return "redirect";
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    n_checks++;
    if (actual !== expected) begin
      n_errors++;
      $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
    end
  endtask

  // reference model walking the image from the model pc
  task automatic check_instr();
    int idx;
    idx = hw_index(model_pc);
    check_value({phase_name(), " pc"}, model_pc, instr_pc_o);
    check_value({phase_name(), " data"}, exp_word[idx], instr_rdata_o);
    check_value({phase_name(), " compressed"}, {31'b0, exp_c[idx]},
                {31'b0, instr_compressed_o});
    check_value({phase_name(), " illegal"}, {31'b0, exp_ill[idx]},
                {31'b0, instr_illegal_o});
    if (exp_ill[idx]) n_illegal++;
    if (exp_c[idx]) n_compressed++;
    if (model_pc[1] && !exp_c[idx]) n_unaligned++;
    model_pc = model_pc + 32'(exp_len[idx]);
    n_done++;
  endtask

  // mid-cycle sample of what the coming edge will take
  task automatic observe_cycle();
    int due;
    if (first_cycle) begin
      check_value("valid after reset", 32'd0, {31'b0, instr_valid_o});
      check_value("boot request", 32'd1, {31'b0, instr_req_o});
      check_value("boot address", ENTRY, instr_addr_o);
      first_cycle = 1'b0;
    end
    if (after_set) begin
      check_value({phase_name(), " valid after pc_set"}, 32'd0, {31'b0, instr_valid_o});
    end
    if (instr_valid_o && instr_ready_i) check_instr();
    // each grant gets its response 1 to 3 cycles later, in order and one per cycle
    if (instr_req_o && instr_gnt_i) begin
      due = cyc + 1 + int'($urandom % 3);
      if (due <= last_due) due = last_due + 1;
      last_due = due;
      rsp_due_q.push_back(due);
      rsp_data_q.push_back(read_word(instr_addr_o));
    end
    after_set = pc_set_i;
    if (pc_set_i) model_pc = pc_target_i;
  endtask

  // just after the edge
  task automatic drive_cycle();
    cyc++;
    if (rsp_due_q.size() != 0 && rsp_due_q[0] <= cyc) begin
      instr_rvalid_i = 1'b1;
      instr_rdata_i  = rsp_data_q.pop_front();
      void'(rsp_due_q.pop_front());
    end else begin
      instr_rvalid_i = 1'b0;
      instr_rdata_i  = $urandom;
    end
    instr_gnt_i   = (($urandom % 4) != 0);
    instr_ready_i = (n_done < MIXED_N) ? 1'b1 : (($urandom % 2) == 0);
    if (n_done >= BP_N && !pc_set_i && ($urandom % 16) == 0) begin
      pc_set_i    = 1'b1;
      pc_target_i = pick_target();
      n_redirects++;
    end else begin
      pc_set_i = 1'b0;
    end
  endtask

  task automatic finish_run(input logic timed_out);
    $display("errors %0d, checks %0d, instructions %0d, redirects %0d",
             n_errors, n_checks, n_done, n_redirects);
    if (n_errors == 0 && !timed_out) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  endtask

  ////////////////////
  // run
  ////////////////////

  initial begin
    void'($urandom(SEED));
    rst_n          = 1'b0;
    boot_addr_i    = BOOT_ADDR;
    pc_set_i       = 1'b0;
    pc_target_i    = '0;
    instr_ready_i  = 1'b0;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    cyc            = 0;
    last_due       = 0;
    n_done         = 0;
    n_errors       = 0;
    n_checks       = 0;
    n_redirects    = 0;
    n_illegal      = 0;
    n_compressed   = 0;
    n_unaligned    = 0;
    first_cycle    = 1'b1;
    after_set      = 1'b0;
    model_pc       = ENTRY;
    fill_program();
    repeat (8) begin
      @(posedge clk);
      #1;
      check_value("valid in reset", 32'd0, {31'b0, instr_valid_o});
      check_value("request in reset", 32'd0, {31'b0, instr_req_o});
    end
    rst_n = 1'b1;
    drive_cycle();
    while (n_done < TOTAL) begin
      @(negedge clk);
      observe_cycle();
      @(posedge clk);
      #1;
      drive_cycle();
    end
    // each behavior has to show up at least once
    check_value("illegal delivered", 32'd1, {31'b0, n_illegal != 0});
    check_value("compressed delivered", 32'd1, {31'b0, n_compressed != 0});
    check_value("unaligned 32-bit delivered", 32'd1, {31'b0, n_unaligned != 0});
    check_value("redirects issued", 32'd1, {31'b0, n_redirects != 0});
    finish_run(1'b0);
  end

  initial timeout_cnt = 0;

  always @(posedge clk) begin
    if (rst_n) begin
      timeout_cnt++;
      if (timeout_cnt >= TIMEOUT) begin
        $display("timeout after %0d cycles with %0d of %0d instructions delivered",
                 timeout_cnt, n_done, TOTAL);
        n_errors++;
        finish_run(1'b1);
      end
    end
  end

endmodule

`default_nettype wire

// ==== if_stage_top.f ====
+incdir+.
if_pkg.sv
fetch_requester.sv
fetch_fifo.sv
compressed_expander.sv
instr_aligner.sv
if_stage_top.sv
if_stage_asserts.sv
if_stage_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= if_stage_tb
FLIST     ?= if_stage_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
